/* Bender.yml */
package:
  name: pu_slave_spi

sources:
  - include_dirs:
      - include
    files:
      - rtl/spi_pu_pkg.sv
      - rtl/spi_slave_driver.sv
      - rtl/spi_buffer.sv
      - rtl/hoarder.sv
      - rtl/spi_pu_ctrl.sv
      - rtl/pu_slave_spi.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_pu_slave_spi.sv

/* compile.f */
+incdir+include
rtl/spi_pu_pkg.sv
rtl/spi_slave_driver.sv
rtl/spi_buffer.sv
rtl/hoarder.sv
rtl/spi_pu_ctrl.sv
rtl/pu_slave_spi.sv
sim/tb_pu_slave_spi.sv

/* include/spi_pu_consts.svh */
`ifndef SPI_PU_CONSTS_SVH
`define SPI_PU_CONSTS_SVH

// system word width
`define PU_DATA_WIDTH 32

// one SPI transfer unit, sent msb first
`define PU_SPI_WIDTH 8

// words held by one bank of a ping-pong pair
`define PU_BUF_SIZE 6

// status bits reported to the system
`define PU_ATTR_WIDTH 4

`endif

/* rtl/hoarder.sv */
`include "spi_pu_consts.svh"

module hoarder
	import spi_pu_pkg::*;
	( input  logic                      clk
	, input  logic                      rst
	, input  logic                      cs_sync
	, input  logic                      byte_done
	, input  logic [`PU_SPI_WIDTH-1:0]  rx_byte
	, input  logic                      byte_req
	, input  logic [`PU_DATA_WIDTH-1:0] tx_word
	, input  buf_status_t               tx_status
	, output logic [`PU_DATA_WIDTH-1:0] rx_word
	, output logic                      rx_word_valid
	, output logic [`PU_SPI_WIDTH-1:0]  tx_byte
	, output logic                      tx_pop
	, output logic                      tx_underrun
	);

	localparam int IDX_W = $clog2(PU_BYTES);
	localparam logic [IDX_W-1:0] LAST = IDX_W'(PU_BYTES - 1);

	spi_word_u        rx_acc;
	// next byte slot to fill, counts down from the msb
	logic [IDX_W-1:0] rx_idx;
	spi_word_u        tx_head;
	spi_word_u        tx_cur;
	// bytes already taken from tx_cur
	logic [IDX_W-1:0] tx_idx;
	logic             need_word;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rx_idx        <= LAST;
			rx_word_valid <= 1'b0;
		end else begin
			rx_word_valid <= 1'b0;
			if (cs_sync) begin
				// leftover bytes of a partial word are dropped
				rx_idx <= LAST;
			end else if (byte_done) begin
				rx_idx <= rx_idx - 1'b1;
				if (rx_idx == '0) begin
					rx_word_valid <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (byte_done && !cs_sync) begin
			rx_acc.bytes[rx_idx] <= rx_byte;
		end
	end

	assign rx_word = rx_acc.word;

	assign tx_head.word = tx_word;
	assign need_word    = byte_req & (tx_idx == '0);
	assign tx_pop       = need_word & ~tx_status.empty;
	assign tx_underrun  = need_word & tx_status.empty;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			tx_idx  <= '0;
			tx_byte <= '0;
			tx_cur  <= '0;
		end else if (cs_sync) begin
			tx_idx <= '0;
		end else if (byte_req) begin
			tx_idx <= tx_idx + 1'b1;
			if (tx_pop) begin
				tx_cur  <= tx_head;
				tx_byte <= tx_head.bytes[LAST];
			end else if (tx_underrun) begin
				// empty bank, the master gets zeros
				tx_cur  <= '0;
				tx_byte <= '0;
			end else begin
				tx_byte <= tx_cur.bytes[LAST - tx_idx];
			end
		end
	end

endmodule

/* rtl/pu_slave_spi.sv */
`include "spi_pu_consts.svh"

module pu_slave_spi
	import spi_pu_pkg::*;
	( input  logic                      clk
	, input  logic                      rst
	, input  logic                      cycle
	// system side
	, input  logic                      wr
	, input  logic [`PU_DATA_WIDTH-1:0] data_in
	, input  logic                      oe
	, output logic [`PU_DATA_WIDTH-1:0] data_out
	, output pu_attr_t                  attr_out
	, output logic                      flag_start
	, output logic                      flag_stop
	// spi side
	, input  logic                      mosi
	, output logic                      miso
	, input  logic                      sclk
	, input  logic                      cs
	);

	bank_sel_t                 sel;
	logic                      rx_clr;
	logic                      tx_clr;
	logic                      cs_sync;
	logic                      cs_fall;
	logic [`PU_SPI_WIDTH-1:0]  rx_byte;
	logic [`PU_SPI_WIDTH-1:0]  tx_byte;
	logic                      byte_done;
	logic                      byte_req;
	logic [`PU_DATA_WIDTH-1:0] rx_word;
	logic                      rx_word_valid;
	logic                      tx_pop;
	logic                      tx_underrun;
	logic [`PU_DATA_WIDTH-1:0] send_data [2];
	buf_status_t               send_status [2];
	logic [`PU_DATA_WIDTH-1:0] recv_data [2];
	buf_status_t               recv_status [2];

	spi_slave_driver spi_driver
		( .clk(clk), .rst(rst)
		, .mosi(mosi), .sclk(sclk), .cs(cs)
		, .tx_byte(tx_byte)
		, .miso(miso)
		, .rx_byte(rx_byte)
		, .byte_done(byte_done)
		, .byte_req(byte_req)
		, .cs_sync(cs_sync)
		, .cs_fall(cs_fall)
		);

	// the hoarder reads the send bank opposite the system's write bank
	hoarder hoarder_i
		( .clk(clk), .rst(rst)
		, .cs_sync(cs_sync)
		, .byte_done(byte_done), .rx_byte(rx_byte)
		, .byte_req(byte_req)
		, .tx_word(send_data[~sel.tx_bank])
		, .tx_status(send_status[~sel.tx_bank])
		, .rx_word(rx_word), .rx_word_valid(rx_word_valid)
		, .tx_byte(tx_byte), .tx_pop(tx_pop), .tx_underrun(tx_underrun)
		);

	spi_pu_ctrl ctrl
		( .clk(clk), .rst(rst)
		, .cycle(cycle), .cs_sync(cs_sync), .cs_fall(cs_fall)
		, .rx_word_valid(rx_word_valid)
		, .rx_full(recv_status[sel.rx_bank].full)
		, .tx_underrun(tx_underrun)
		, .rd_status(recv_status[~sel.rx_bank])
		, .sel(sel), .rx_clr(rx_clr), .tx_clr(tx_clr)
		, .flag_start(flag_start), .flag_stop(flag_stop)
		, .attr(attr_out)
		);

	spi_buffer send_buf0
		( .clk(clk), .rst(rst)
		, .clr(tx_clr & ~sel.tx_bank)
		, .wr(wr & ~sel.tx_bank), .data_in(data_in)
		, .rd(tx_pop & sel.tx_bank)
		, .data_out(send_data[0]), .status(send_status[0])
		);

	spi_buffer send_buf1
		( .clk(clk), .rst(rst)
		, .clr(tx_clr & sel.tx_bank)
		, .wr(wr & sel.tx_bank), .data_in(data_in)
		, .rd(tx_pop & ~sel.tx_bank)
		, .data_out(send_data[1]), .status(send_status[1])
		);

	spi_buffer recv_buf0
		( .clk(clk), .rst(rst)
		, .clr(rx_clr & ~sel.rx_bank)
		, .wr(rx_word_valid & ~sel.rx_bank), .data_in(rx_word)
		, .rd(oe & sel.rx_bank)
		, .data_out(recv_data[0]), .status(recv_status[0])
		);

	spi_buffer recv_buf1
		( .clk(clk), .rst(rst)
		, .clr(rx_clr & sel.rx_bank)
		, .wr(rx_word_valid & sel.rx_bank), .data_in(rx_word)
		, .rd(oe & ~sel.rx_bank)
		, .data_out(recv_data[1]), .status(recv_status[1])
		);

	assign data_out = recv_data[~sel.rx_bank];

endmodule

/* rtl/spi_buffer.sv */
`include "spi_pu_consts.svh"

module spi_buffer
	import spi_pu_pkg::*;
	( input  logic                      clk
	, input  logic                      rst
	, input  logic                      clr
	, input  logic                      wr
	, input  logic [`PU_DATA_WIDTH-1:0] data_in
	, input  logic                      rd
	, output logic [`PU_DATA_WIDTH-1:0] data_out
	, output buf_status_t               status
	);

	localparam int PTR_W = $clog2(`PU_BUF_SIZE);

	logic [`PU_DATA_WIDTH-1:0] mem [`PU_BUF_SIZE];
	logic [PTR_W-1:0]          wr_ptr;
	logic [PTR_W-1:0]          rd_ptr;
	buf_count_t                count;
	logic                      do_wr;
	logic                      do_rd;

	assign do_wr = wr & ~status.full;
	assign do_rd = rd & ~status.empty;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (clr) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= (wr_ptr == PTR_W'(`PU_BUF_SIZE - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= (rd_ptr == PTR_W'(`PU_BUF_SIZE - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// simultaneous push and pop leaves the count alone
			if (do_wr && !do_rd) begin
				count <= count + 1'b1;
			end else if (do_rd && !do_wr) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (do_wr && !clr) begin
			mem[wr_ptr] <= data_in;
		end
	end

	assign data_out     = mem[rd_ptr];
	assign status.count = count;
	assign status.empty = (count == '0);
	assign status.full  = (count == buf_count_t'(`PU_BUF_SIZE));

	a_count_bound: assert property (@(posedge clk) disable iff (rst)
		count <= buf_count_t'(`PU_BUF_SIZE));

endmodule

/* rtl/spi_pu_ctrl.sv */
`include "spi_pu_consts.svh"

module spi_pu_ctrl
	import spi_pu_pkg::*;
	( input  logic        clk
	, input  logic        rst
	, input  logic        cycle
	, input  logic        cs_sync
	, input  logic        cs_fall
	, input  logic        rx_word_valid
	, input  logic        rx_full
	, input  logic        tx_underrun
	, input  buf_status_t rd_status
	, output bank_sel_t   sel
	, output logic        rx_clr
	, output logic        tx_clr
	, output logic        flag_start
	, output logic        flag_stop
	, output pu_attr_t    attr
	);

	logic pending;
	logic swap;
	logic overflow;
	logic underrun;

	if ($bits(pu_attr_t) != `PU_ATTR_WIDTH) begin : g_attr_width
		$error("pu_attr_t width does not match PU_ATTR_WIDTH");
	end

	// banks only move between transactions
	assign swap = cs_sync & (cycle | pending);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pending <= 1'b0;
			sel     <= '0;
			rx_clr  <= 1'b0;
			tx_clr  <= 1'b0;
		end else begin
			rx_clr <= swap;
			tx_clr <= swap;
			if (swap) begin
				pending     <= 1'b0;
				sel.rx_bank <= ~sel.rx_bank;
				sel.tx_bank <= ~sel.tx_bank;
			end else if (cycle) begin
				// cs low, hold the request until it rises
				pending <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			flag_start <= 1'b0;
			overflow   <= 1'b0;
			underrun   <= 1'b0;
		end else begin
			flag_start <= cs_fall;
			if (swap) begin
				overflow <= 1'b0;
				underrun <= 1'b0;
			end else begin
				if (rx_word_valid && rx_full) begin
					overflow <= 1'b1;
				end
				if (tx_underrun) begin
					underrun <= 1'b1;
				end
			end
		end
	end

	assign flag_stop     = cs_sync;
	assign attr.valid    = ~rd_status.empty;
	assign attr.overflow = overflow;
	assign attr.underrun = underrun;
	assign attr.busy     = ~cs_sync;

	a_clr_idle: assert property (@(posedge clk) disable iff (rst)
		(rx_clr || tx_clr) |-> cs_sync);

endmodule

/* rtl/spi_pu_pkg.sv */
`include "spi_pu_consts.svh"

package spi_pu_pkg;

	// number of bytes per system word
	localparam int PU_BYTES = `PU_DATA_WIDTH / `PU_SPI_WIDTH;

	typedef logic [$clog2(`PU_BUF_SIZE + 1)-1:0] buf_count_t;

	// one word seen whole or as bytes, bytes[3] travels first
	typedef union packed {
		logic [`PU_DATA_WIDTH-1:0] word;
		logic [PU_BYTES-1:0][`PU_SPI_WIDTH-1:0] bytes;
	} spi_word_u;

	typedef struct packed {
		buf_count_t count;
		logic empty;
		logic full;
	} buf_status_t;

	// write side of each pair, the other bank is the read side
	typedef struct packed {
		logic rx_bank;
		logic tx_bank;
	} bank_sel_t;

	typedef struct packed {
		logic busy;
		logic underrun;
		logic overflow;
		logic valid;
	} pu_attr_t;

endpackage

/* rtl/spi_slave_driver.sv */
`include "spi_pu_consts.svh"

module spi_slave_driver
	( input  logic                     clk
	, input  logic                     rst
	, input  logic                     mosi
	, input  logic                     sclk
	, input  logic                     cs
	, input  logic [`PU_SPI_WIDTH-1:0] tx_byte
	, output logic                     miso
	, output logic [`PU_SPI_WIDTH-1:0] rx_byte
	, output logic                     byte_done
	, output logic                     byte_req
	, output logic                     cs_sync
	, output logic                     cs_fall
	);

	localparam int W     = `PU_SPI_WIDTH;
	localparam int CNT_W = $clog2(W);

	// [0] meta, [1] sync, [2] previous sync
	logic [2:0]       sclk_q;
	logic [2:0]       cs_q;
	logic [1:0]       mosi_q;
	logic             sclk_rise;
	logic             sclk_fall;
	logic             load_tx;
	logic [CNT_W-1:0] bit_cnt;
	logic [W-1:0]     rx_shift;
	logic [W-1:0]     tx_shift;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			sclk_q <= '0;
			cs_q   <= '1;
			mosi_q <= '0;
		end else begin
			sclk_q <= {sclk_q[1:0], sclk};
			cs_q   <= {cs_q[1:0], cs};
			mosi_q <= {mosi_q[0], mosi};
		end
	end

	assign sclk_rise = sclk_q[1] & ~sclk_q[2];
	assign sclk_fall = ~sclk_q[1] & sclk_q[2];
	assign cs_sync   = cs_q[1];
	assign cs_fall   = cs_q[2] & ~cs_q[1];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			bit_cnt   <= '0;
			rx_shift  <= '0;
			tx_shift  <= '0;
			byte_done <= 1'b0;
			byte_req  <= 1'b0;
			load_tx   <= 1'b0;
		end else begin
			byte_done <= 1'b0;
			byte_req  <= cs_fall;
			load_tx   <= byte_req;
			if (cs_sync) begin
				bit_cnt <= '0;
			end else if (sclk_rise) begin
				rx_shift <= {rx_shift[W-2:0], mosi_q[1]};
				bit_cnt  <= bit_cnt + 1'b1;
				// last bit of the byte, ask for the next one too
				if (bit_cnt == CNT_W'(W - 1)) begin
					byte_done <= 1'b1;
					byte_req  <= 1'b1;
				end
			end else if (sclk_fall && bit_cnt != '0) begin
				// no shift on the fall that follows a whole byte
				tx_shift <= {tx_shift[W-2:0], 1'b0};
			end
			// hoarder answers a request one cycle later
			if (load_tx) begin
				tx_shift <= tx_byte;
			end
		end
	end

	assign rx_byte = rx_shift;
	assign miso    = tx_shift[W-1];

	a_byte_in_frame: assert property (@(posedge clk) disable iff (rst)
		byte_done |-> !cs_sync);

endmodule

/* sim/tb_pu_slave_spi.sv */
`include "spi_pu_consts.svh"

module tb_pu_slave_spi
	import spi_pu_pkg::*;
	();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int W       = `PU_DATA_WIDTH;
	// sclk half period in clk cycles
	localparam int HALF    = 8;
	localparam int TIMEOUT = 200;

	logic         clk;
	logic         rst;
	logic         cycle;
	logic         wr;
	logic [W-1:0] data_in;
	logic         oe;
	logic [W-1:0] data_out;
	pu_attr_t     attr_out;
	logic         flag_start;
	logic         flag_stop;
	logic         mosi;
	logic         miso;
	logic         sclk;
	logic         cs;
	logic [31:0]  rng = 32'h8678_451c;
	int           frames = 0;
	int           start_pulses = 0;

	pu_slave_spi UUT
		( .clk(clk), .rst(rst), .cycle(cycle)
		, .wr(wr), .data_in(data_in), .oe(oe), .data_out(data_out)
		, .attr_out(attr_out), .flag_start(flag_start), .flag_stop(flag_stop)
		, .mosi(mosi), .miso(miso), .sclk(sclk), .cs(cs)
		);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		if (flag_start === 1'b1) begin
			start_pulses++;
		end
	end

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check(input string name, input logic [W-1:0] actual,
			input logic [W-1:0] expected);
		if (actual !== expected) begin
			fail_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, actual, expected));
		end
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// byte n of a word where n = 0 is the msb that goes out first
	function automatic logic [7:0] byte_of(input logic [W-1:0] w, input int n);
		logic [W-1:0] s;
		s = w >> (8 * (3 - n));
		return s[7:0];
	endfunction

	// inputs change 1 ns after the rising edge
	task automatic step(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic write_word(input logic [W-1:0] w);
		wr      = 1'b1;
		data_in = w;
		step(1);
		wr      = 1'b0;
	endtask

	task automatic pop_check(input logic [W-1:0] expected);
		check("data_out", data_out, expected);
		oe = 1'b1;
		step(1);
		oe = 1'b0;
	endtask

	task automatic pulse_cycle();
		cycle = 1'b1;
		step(1);
		cycle = 1'b0;
		step(2);
	endtask

	task automatic begin_frame();
		int n = 0;
		cs = 1'b0;
		frames++;
		while (flag_start !== 1'b1 && n < TIMEOUT) begin
			step(1);
			n++;
		end
		if (flag_start !== 1'b1) begin
			fail_run("Timeout: flag_start never pulsed after cs fell");
		end
		step(2);
	endtask

	task automatic end_frame();
		int n = 0;
		step(4);
		cs = 1'b1;
		while (flag_stop !== 1'b1 && n < TIMEOUT) begin
			step(1);
			n++;
		end
		if (flag_stop !== 1'b1) begin
			fail_run("Timeout: flag_stop never rose after cs went high");
		end
		step(2);
		// exactly one start pulse per cs fall
		check("flag_start pulses", start_pulses, frames);
	endtask

	// mode 0 master that sets mosi while sclk is low and samples miso before the rise
	task automatic exchange_byte(input logic [7:0] tx, output logic [7:0] rx);
		for (int i = 7; i >= 0; i--) begin
			mosi  = tx[i];
			step(HALF);
			rx[i] = miso;
			sclk  = 1'b1;
			step(HALF);
			sclk  = 1'b0;
		end
	endtask

	task automatic exchange_word(input logic [W-1:0] tx, output logic [W-1:0] rx);
		logic [7:0] b;
		rx = '0;
		for (int n = 0; n < 4; n++) begin
			exchange_byte(byte_of(tx, n), b);
			rx = {rx[W-9:0], b};
		end
	endtask

	task automatic reset_values();
		check("attr_out", attr_out, 0);
		check("flag_start", flag_start, 0);
		check("flag_stop", flag_stop, 1);
		check("miso", miso, 0);
	endtask

	task automatic master_to_system();
		logic [W-1:0] sent [4];
		logic [W-1:0] echo;
		for (int i = 0; i < 4; i++) begin
			sent[i] = {8'ha0 + 8'(i), 8'hb1, 8'hc2 + 8'(i), 8'hd3};
		end
		begin_frame();
		for (int i = 0; i < 4; i++) begin
			exchange_word(sent[i], echo);
		end
		end_frame();
		check("attr_out.valid", attr_out.valid, 0);
		pulse_cycle();
		check("attr_out.valid", attr_out.valid, 1);
		for (int i = 0; i < 4; i++) begin
			pop_check(sent[i]);
		end
		check("attr_out.valid", attr_out.valid, 0);
	endtask

	task automatic system_to_master();
		logic [W-1:0] words [3];
		logic [7:0]   got;
		logic [7:0]   expected;
		for (int i = 0; i < 3; i++) begin
			rng      = xorshift32(rng);
			words[i] = rng;
			write_word(words[i]);
		end
		pulse_cycle();
		begin_frame();
		for (int n = 0; n < 14; n++) begin
			exchange_byte(8'h00, got);
			expected = (n < 12) ? byte_of(words[n / 4], n % 4) : 8'h00;
			check("miso byte", got, expected);
		end
		end_frame();
		check("attr_out.underrun", attr_out.underrun, 1);
		pulse_cycle();
		check("attr_out.underrun", attr_out.underrun, 0);
		// the zeros from the master form three whole words
		for (int i = 0; i < 3; i++) begin
			pop_check('0);
		end
		check("attr_out.valid", attr_out.valid, 0);
	endtask

	task automatic full_duplex();
		logic [W-1:0] tx_batch [2][3];
		logic [W-1:0] rx_batch [2][3];
		logic [W-1:0] got;
		for (int b = 0; b < 2; b++) begin
			for (int i = 0; i < 3; i++) begin
				rng            = xorshift32(rng);
				tx_batch[b][i] = rng;
				rng            = xorshift32(rng);
				rx_batch[b][i] = rng;
			end
		end
		for (int i = 0; i < 3; i++) begin
			write_word(tx_batch[0][i]);
		end
		pulse_cycle();
		for (int b = 0; b < 2; b++) begin
			// next batch fills the other send bank
			if (b == 0) begin
				for (int i = 0; i < 3; i++) begin
					write_word(tx_batch[1][i]);
				end
			end
			begin_frame();
			for (int i = 0; i < 3; i++) begin
				exchange_word(rx_batch[b][i], got);
				check("miso word", got, tx_batch[b][i]);
			end
			end_frame();
			// received words stay hidden until the swap
			check("attr_out.valid", attr_out.valid, 0);
			pulse_cycle();
			for (int i = 0; i < 3; i++) begin
				pop_check(rx_batch[b][i]);
			end
		end
	endtask

	task automatic overflow_and_partial();
		logic [W-1:0] words [7];
		logic [W-1:0] got;
		logic [7:0]   b;
		for (int i = 0; i < 7; i++) begin
			rng      = xorshift32(rng);
			words[i] = rng;
		end
		begin_frame();
		for (int i = 0; i < 7; i++) begin
			exchange_word(words[i], got);
		end
		end_frame();
		check("attr_out.overflow", attr_out.overflow, 1);
		pulse_cycle();
		check("attr_out.overflow", attr_out.overflow, 0);
		for (int i = 0; i < 6; i++) begin
			pop_check(words[i]);
		end
		check("attr_out.valid", attr_out.valid, 0);
		// one whole word and one stray byte
		begin_frame();
		exchange_word(words[6], got);
		exchange_byte(8'h5a, b);
		end_frame();
		pulse_cycle();
		pop_check(words[6]);
		check("attr_out.valid", attr_out.valid, 0);
	endtask

	task automatic flags_and_deferred_swap();
		logic [W-1:0] word;
		logic [W-1:0] got;
		rng  = xorshift32(rng);
		word = rng;
		begin_frame();
		check("flag_stop", flag_stop, 0);
		check("attr_out.busy", attr_out.busy, 1);
		exchange_word(word, got);
		cycle = 1'b1;
		step(1);
		cycle = 1'b0;
		step(HALF);
		check("attr_out.valid", attr_out.valid, 0);
		end_frame();
		// the held swap went through once cs rose
		check("attr_out.valid", attr_out.valid, 1);
		pop_check(word);
		check("attr_out.valid", attr_out.valid, 0);
	endtask

	initial begin
		rst     = 1'b1;
		cycle   = 1'b0;
		wr      = 1'b0;
		data_in = '0;
		oe      = 1'b0;
		mosi    = 1'b0;
		sclk    = 1'b0;
		cs      = 1'b1;
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		step(3);
		reset_values();
		master_to_system();
		system_to_master();
		full_duplex();
		overflow_and_partial();
		flags_and_deferred_swap();
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule
